//--- bench/hazard_ctrl_tb.sv
`timescale 1ns/1ns

module hazard_ctrl_tb
	import rv_isa_pkg::*;
();

	localparam logic [31:0] seed_value = 32'hc416_7d33;
	localparam int num_instr = 400;
	localparam int reset_cycles = 8;
	// Each instruction may stall once, plus reset, drain and margin
	localparam int max_cycles = reset_cycles + 2 * num_instr + 192;

	// Reference view of one instruction slot
	typedef struct packed {
		reg_idx_t rs_a;
		reg_idx_t rs_b;
		reg_idx_t rd;
		logic     wr_en;
		logic     is_load;
		logic     is_jalr;
		logic     id_use_a;
		logic     id_use_b;
		logic     exe_use_a;
		logic     exe_use_b;
	} slot_t;

	typedef struct packed {
		logic       stall;
		xlen_word_t id_a;
		xlen_word_t id_b;
		xlen_word_t exe_a;
		xlen_word_t exe_b;
	} expect_t;

	logic       clk = 1'b0;
	logic       rst = 1'b1;
	instr_t     id_instr;
	logic       id_is_comp;
	logic       id_comp_use_a;
	logic       id_comp_use_b;
	xlen_word_t rf_rdata_a;
	xlen_word_t rf_rdata_b;
	xlen_word_t exe_alu_result;
	xlen_word_t mem_result;
	xlen_word_t mem_load_data;
	xlen_word_t wb_wdata;
	logic       stall;
	xlen_word_t id_opnd_a;
	xlen_word_t id_opnd_b;
	xlen_word_t exe_opnd_a;
	xlen_word_t exe_opnd_b;

	// Model history, EXE youngest to WB
	slot_t      hist_exe = '0;
	slot_t      hist_mem = '0;
	slot_t      hist_wb = '0;
	xlen_word_t base_a = '0;
	xlen_word_t base_b = '0;
	logic       hold_id = 1'b0;
	reg_idx_t   last_rd = '0;
	logic       last_was_load = 1'b0;
	int         cycle_count = 0;
	int         stall_count = 0;
	int         issued = 0;

	always #4 clk = ~clk;

	hazard_ctrl_top dut (.*);

	// x0 and non-writing slots never match
	function automatic logic writes_reg(input reg_idx_t src, input slot_t dst);
		return dst.wr_en && (src != 5'd0) && (src == dst.rd);
	endfunction

	function automatic slot_t decode_slot(input instr_t instr, input logic comp,
		input logic use_a, input logic use_b);
		slot_t   s;
		opcode_t op;
		op = instr[6:0];
		s.rs_a = instr[19:15];
		s.rs_b = instr[24:20];
		s.rd = instr[11:7];
		s.wr_en = (op != op_store) && (op != op_branch) && (s.rd != 5'd0);
		s.is_load = (op == op_load);
		s.is_jalr = (op == op_jalr);
		// U and J formats read no rs1
		s.id_use_a = !((op == op_lui) || (op == op_auipc) || (op == op_jal));
		s.id_use_b = (op == op_op) || (op == op_branch) || (op == op_store);
		// Expanded compressed ones carry their own use flags into EXE
		s.exe_use_a = comp ? use_a : s.id_use_a;
		s.exe_use_b = comp ? use_b : s.id_use_b;
		return s;
	endfunction

	// Youngest writer first, loads in EXE have no value yet
	function automatic xlen_word_t id_source(input logic used, input reg_idx_t src,
		input xlen_word_t rf_val);
		if (!used) return rf_val;
		if (writes_reg(src, hist_exe) && !hist_exe.is_load) return exe_alu_result;
		if (writes_reg(src, hist_mem)) return mem_result;
		if (writes_reg(src, hist_wb)) return wb_wdata;
		return rf_val;
	endfunction

	// Only load results get forwarded into EXE
	function automatic xlen_word_t exe_source(input logic used, input reg_idx_t src,
		input xlen_word_t base);
		if (used && hist_mem.is_load && writes_reg(src, hist_mem)) return mem_load_data;
		if (used && hist_wb.is_load && writes_reg(src, hist_wb)) return wb_wdata;
		return base;
	endfunction

	function automatic expect_t model_expect(input slot_t id_s);
		expect_t e;
		e.stall = id_s.is_jalr && hist_exe.is_load && writes_reg(id_s.rs_a, hist_exe);
		e.id_a = id_source(id_s.id_use_a, id_s.rs_a, rf_rdata_a);
		e.id_b = id_source(id_s.id_use_b, id_s.rs_b, rf_rdata_b);
		e.exe_a = exe_source(hist_exe.exe_use_a, hist_exe.rs_a, base_a);
		e.exe_b = exe_source(hist_exe.exe_use_b, hist_exe.rs_b, base_b);
		return e;
	endfunction

	task automatic check_value(input string name, input xlen_word_t expected,
		input xlen_word_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s cycle %0d expected %h actual %h", name, cycle_count,
				expected, actual);
			$display("Verification failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic randomize_data();
		rf_rdata_a = $urandom();
		rf_rdata_b = $urandom();
		exe_alu_result = $urandom();
		mem_result = $urandom();
		mem_load_data = $urandom();
		wb_wdata = $urandom();
	endtask

	task automatic issue_instr();
		logic [31:0] r;
		opcode_t     op;
		reg_idx_t    rd;
		reg_idx_t    rs1;
		reg_idx_t    rs2;
		r = $urandom();
		case ($urandom_range(8))
			0: op = op_lui;
			1: op = op_auipc;
			2: op = op_jal;
			3: op = op_jalr;
			4: op = op_branch;
			5: op = op_load;
			6: op = op_store;
			7: op = op_op_imm;
			default: op = op_op;
		endcase
		// Registers x0..x7 only, so hazards are common
		rd = {2'b00, r[2:0]};
		rs2 = {2'b00, r[5:3]};
		rs1 = r[6] ? last_rd : {2'b00, r[9:7]};
		// Now and then a JALR right behind a load on its result
		if (last_was_load && (r[11:10] == 2'b00)) begin
			op = op_jalr;
			rs1 = last_rd;
		end
		id_instr = {r[31:25], rs2, rs1, r[14:12], rd, op};
		id_is_comp = ($urandom_range(4) == 0);
		id_comp_use_a = r[15];
		id_comp_use_b = r[16];
		last_rd = rd;
		last_was_load = (op == op_load);
	endtask

	// Inputs are settled here, compare then shift the model
	always @(negedge clk) begin : compare_step
		slot_t   id_s;
		expect_t e;
		id_s = decode_slot(id_instr, id_is_comp, id_comp_use_a, id_comp_use_b);
		e = model_expect(id_s);
		if (rst === 1'b0) begin
			check_value("stall", {31'd0, e.stall}, {31'd0, stall});
			check_value("id_opnd_a", e.id_a, id_opnd_a);
			check_value("id_opnd_b", e.id_b, id_opnd_b);
			check_value("exe_opnd_a", e.exe_a, exe_opnd_a);
			check_value("exe_opnd_b", e.exe_b, exe_opnd_b);
			if (e.stall)
				stall_count = stall_count + 1;
		end
		hist_wb = hist_mem;
		hist_mem = hist_exe;
		// Bubble into EXE on stall and during reset
		hist_exe = ((rst !== 1'b0) || e.stall) ? '0 : id_s;
		base_a = e.id_a;
		base_b = e.id_b;
		hold_id = (rst === 1'b0) && e.stall;
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("Run did not end within %0d cycles", max_cycles);
			$display("Verification failed");
			$fatal(1, "timeout");
		end
	end

	initial begin
		void'($urandom(seed_value));
		// addi x0, x0, 0 while in reset
		id_instr = {25'd0, op_op_imm};
		id_is_comp = 1'b0;
		id_comp_use_a = 1'b0;
		id_comp_use_b = 1'b0;
		randomize_data();
		repeat (reset_cycles) begin
			@(posedge clk);
			#1;
			randomize_data();
		end
		rst = 1'b0;
		while (issued < num_instr) begin
			// Held instruction stays in ID for one more cycle
			if (!hold_id) begin
				issue_instr();
				issued = issued + 1;
			end
			@(posedge clk);
			#1;
			randomize_data();
		end
		// Drain through WB
		repeat (4) begin
			@(posedge clk);
			#1;
			randomize_data();
		end
		if (stall_count == 0) begin
			$display("No load to JALR stall occurred in the instruction stream");
			$display("Verification failed");
			$fatal(1, "stall case not reached");
		end else begin
			$display("Verification passed");
			$finish;
		end
	end

endmodule

//--- build.f
rtl/rv_isa_pkg.sv
rtl/pipe_ctrl_pkg.sv
rtl/id_operand_decode.sv
rtl/stage_tracker.sv
rtl/forwarding_unit.sv
rtl/operand_forward_mux.sv
rtl/hazard_ctrl_top.sv
bench/hazard_ctrl_tb.sv

//--- rtl/forwarding_unit.sv
`timescale 1ns/1ns

module forwarding_unit
	import rv_isa_pkg::*;
	import pipe_ctrl_pkg::*;
(
	input  id_ctrl_t    id_ctrl,
	input  stage_ctrl_t exe_ctrl,
	input  stage_ctrl_t mem_ctrl,
	input  stage_ctrl_t wb_ctrl,
	output fwd_flags_t  fwd
);

	// Source matches a writing destination, x0 excluded
	function automatic logic reg_hit(input reg_idx_t src, input stage_ctrl_t dst);
		return (src == dst.rd) && (src != reg_x0) && dst.wr_en;
	endfunction

	reg_idx_t id_rs_a;
	reg_idx_t id_rs_b;
	logic     id_use_a;
	logic     id_use_b;
	logic     exe_is_load;
	logic     mem_is_load;
	logic     wb_is_load;
	logic     base_use_a;
	logic     base_use_b;
	logic     exe_use_a;
	logic     exe_use_b;

	assign id_rs_a = id_ctrl.stage.rs_a;
	assign id_rs_b = id_ctrl.stage.rs_b;

	// Operand A in ID, never for U or J formats
	assign id_use_a = id_ctrl.sel_op_a &&
		!(id_ctrl.imm_select == imm_u || id_ctrl.imm_select == imm_j);

	// Operand B in ID, ALU rs2 or store data
	assign id_use_b = !id_ctrl.sel_op_b || id_ctrl.is_stype;

	// Load data shows up only after MEM
	assign exe_is_load = (exe_ctrl.sel_data == wb_load);
	assign mem_is_load = (mem_ctrl.sel_data == wb_load);
	assign wb_is_load  = (wb_ctrl.sel_data == wb_load);

	// EXE ALU result to ID, loads are not ready yet
	assign fwd.fw_exe_to_id_A = reg_hit(id_rs_a, exe_ctrl) && !exe_is_load && id_use_a;
	assign fwd.fw_exe_to_id_B = reg_hit(id_rs_b, exe_ctrl) && !exe_is_load && id_use_b;

	// EXE/MEM register to ID
	assign fwd.fw_mem_to_id_A = reg_hit(id_rs_a, mem_ctrl) && id_use_a;
	assign fwd.fw_mem_to_id_B = reg_hit(id_rs_b, mem_ctrl) && id_use_b;

	// MEM/WB register to ID
	assign fwd.fw_wb_to_id_A = reg_hit(id_rs_a, wb_ctrl) && id_use_a;
	assign fwd.fw_wb_to_id_B = reg_hit(id_rs_b, wb_ctrl) && id_use_b;

	// A used by all but LUI, AUIPC, JAL
	assign base_use_a = !(exe_ctrl.opcode == op_lui || exe_ctrl.opcode == op_auipc ||
		exe_ctrl.opcode == op_jal);

	// B used by R-type, branch, store
	assign base_use_b = base_use_a && (exe_ctrl.opcode == op_op ||
		exe_ctrl.opcode == op_branch || exe_ctrl.opcode == op_store);

	// Compressed instructions bring their own use flags
	assign exe_use_a = exe_ctrl.is_comp ? exe_ctrl.comp_use_a : base_use_a;
	assign exe_use_b = exe_ctrl.is_comp ? exe_ctrl.comp_use_b : base_use_b;

	// Load two stages ahead, WB value into EXE
	assign fwd.fw_wb_to_exe_A = reg_hit(exe_ctrl.rs_a, wb_ctrl) && wb_is_load && exe_use_a;
	assign fwd.fw_wb_to_exe_B = reg_hit(exe_ctrl.rs_b, wb_ctrl) && wb_is_load && exe_use_b;

	// Load in EXE feeding a JALR base, needs one stall
	assign fwd.hzd_exe_to_id_A = reg_hit(id_rs_a, exe_ctrl) && exe_is_load &&
		id_ctrl.sel_op_br;

	// Load in MEM feeding EXE, memory read data goes straight in
	assign fwd.hzd_mem_to_exe_A = reg_hit(exe_ctrl.rs_a, mem_ctrl) && mem_is_load &&
		exe_use_a;
	assign fwd.hzd_mem_to_exe_B = reg_hit(exe_ctrl.rs_b, mem_ctrl) && mem_is_load &&
		exe_use_b;

endmodule

//--- rtl/hazard_ctrl_top.sv
`timescale 1ns/1ns

module hazard_ctrl_top
	import rv_isa_pkg::*;
	import pipe_ctrl_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  instr_t     id_instr,
	input  logic       id_is_comp,
	input  logic       id_comp_use_a,
	input  logic       id_comp_use_b,
	input  xlen_word_t rf_rdata_a,
	input  xlen_word_t rf_rdata_b,
	input  xlen_word_t exe_alu_result,
	input  xlen_word_t mem_result,
	input  xlen_word_t mem_load_data,
	input  xlen_word_t wb_wdata,
	output logic       stall,
	output xlen_word_t id_opnd_a,
	output xlen_word_t id_opnd_b,
	output xlen_word_t exe_opnd_a,
	output xlen_word_t exe_opnd_b
);

	id_ctrl_t    id_ctrl;
	stage_ctrl_t exe_ctrl;
	stage_ctrl_t mem_ctrl;
	stage_ctrl_t wb_ctrl;
	fwd_flags_t  fwd;
	xlen_word_t  exe_base_a;
	xlen_word_t  exe_base_b;

	// Only load-to-JALR holds ID
	assign stall = fwd.hzd_exe_to_id_A;

	id_operand_decode u_decode (
		.id_instr      (id_instr),
		.id_is_comp    (id_is_comp),
		.id_comp_use_a (id_comp_use_a),
		.id_comp_use_b (id_comp_use_b),
		.id_ctrl       (id_ctrl)
	);

	stage_tracker u_tracker (
		.clk        (clk),
		.rst        (rst),
		.id_ctrl    (id_ctrl),
		.stall      (stall),
		.id_opnd_a  (id_opnd_a),
		.id_opnd_b  (id_opnd_b),
		.exe_ctrl   (exe_ctrl),
		.mem_ctrl   (mem_ctrl),
		.wb_ctrl    (wb_ctrl),
		.exe_base_a (exe_base_a),
		.exe_base_b (exe_base_b)
	);

	forwarding_unit u_fwd (
		.id_ctrl  (id_ctrl),
		.exe_ctrl (exe_ctrl),
		.mem_ctrl (mem_ctrl),
		.wb_ctrl  (wb_ctrl),
		.fwd      (fwd)
	);

	operand_forward_mux u_mux (
		.fwd            (fwd),
		.rf_rdata_a     (rf_rdata_a),
		.rf_rdata_b     (rf_rdata_b),
		.exe_alu_result (exe_alu_result),
		.mem_result     (mem_result),
		.wb_wdata       (wb_wdata),
		.mem_load_data  (mem_load_data),
		.exe_base_a     (exe_base_a),
		.exe_base_b     (exe_base_b),
		.id_opnd_a      (id_opnd_a),
		.id_opnd_b      (id_opnd_b),
		.exe_opnd_a     (exe_opnd_a),
		.exe_opnd_b     (exe_opnd_b)
	);

endmodule

//--- rtl/id_operand_decode.sv
`timescale 1ns/1ns

module id_operand_decode
	import rv_isa_pkg::*;
	import pipe_ctrl_pkg::*;
(
	input  instr_t   id_instr,
	input  logic     id_is_comp,
	input  logic     id_comp_use_a,
	input  logic     id_comp_use_b,
	output id_ctrl_t id_ctrl
);

	opcode_t  opcode;
	reg_idx_t rd;
	logic     no_write;

	assign opcode = id_instr[6:0];
	assign rd     = id_instr[11:7];

	// Stores and branches never write rd
	assign no_write = (opcode == op_store) || (opcode == op_branch);

	always_comb begin
		// Register fields sit at fixed positions in every format
		id_ctrl.stage.rs_a       = id_instr[19:15];
		id_ctrl.stage.rs_b       = id_instr[24:20];
		id_ctrl.stage.rd         = rd;
		id_ctrl.stage.wr_en      = !no_write && (rd != reg_x0);
		id_ctrl.stage.opcode     = opcode;
		// Compressed info rides along for the EXE use check
		id_ctrl.stage.is_comp    = id_is_comp;
		id_ctrl.stage.comp_use_a = id_comp_use_a;
		id_ctrl.stage.comp_use_b = id_comp_use_b;

		// Write-back source by opcode class
		case (opcode)
			op_load:         id_ctrl.stage.sel_data = wb_load;
			op_jal, op_jalr: id_ctrl.stage.sel_data = wb_pc4;
			op_lui:          id_ctrl.stage.sel_data = wb_imm;
			default:         id_ctrl.stage.sel_data = wb_alu;
		endcase

		// Immediate format
		case (opcode)
			op_store:           id_ctrl.imm_select = imm_s;
			op_lui, op_auipc:   id_ctrl.imm_select = imm_u;
			op_branch:          id_ctrl.imm_select = imm_b;
			op_jal:             id_ctrl.imm_select = imm_j;
			// I-type, and R-type where it is unused
			default:            id_ctrl.imm_select = imm_i;
		endcase

		// rs1 feeds the ALU or jump adder except for U and J
		id_ctrl.sel_op_a = !((opcode == op_lui) || (opcode == op_auipc) ||
			(opcode == op_jal));

		// Low means rs2 is the second ALU operand
		id_ctrl.sel_op_b = !((opcode == op_op) || (opcode == op_branch));

		// Store data comes from rs2 too
		id_ctrl.is_stype = (opcode == op_store);

		// JALR base goes to the jump adder
		id_ctrl.sel_op_br = (opcode == op_jalr);
	end

endmodule

//--- rtl/operand_forward_mux.sv
`timescale 1ns/1ns

module operand_forward_mux
	import rv_isa_pkg::*;
	import pipe_ctrl_pkg::*;
(
	input  fwd_flags_t fwd,
	input  xlen_word_t rf_rdata_a,
	input  xlen_word_t rf_rdata_b,
	input  xlen_word_t exe_alu_result,
	input  xlen_word_t mem_result,
	input  xlen_word_t wb_wdata,
	input  xlen_word_t mem_load_data,
	input  xlen_word_t exe_base_a,
	input  xlen_word_t exe_base_b,
	output xlen_word_t id_opnd_a,
	output xlen_word_t id_opnd_b,
	output xlen_word_t exe_opnd_a,
	output xlen_word_t exe_opnd_b
);

	// Youngest producer wins, register file last
	function automatic xlen_word_t pick_id(input logic from_exe, input logic from_mem,
		input logic from_wb, input xlen_word_t rf_val);
		if (from_exe)
			return exe_alu_result;
		else if (from_mem)
			return mem_result;
		else if (from_wb)
			return wb_wdata;
		return rf_val;
	endfunction

	// Load in MEM is newer than load in WB
	function automatic xlen_word_t pick_exe(input logic from_mem, input logic from_wb,
		input xlen_word_t base);
		if (from_mem)
			return mem_load_data;
		else if (from_wb)
			return wb_wdata;
		return base;
	endfunction

	always_comb begin
		id_opnd_a  = pick_id(fwd.fw_exe_to_id_A, fwd.fw_mem_to_id_A, fwd.fw_wb_to_id_A,
			rf_rdata_a);
		id_opnd_b  = pick_id(fwd.fw_exe_to_id_B, fwd.fw_mem_to_id_B, fwd.fw_wb_to_id_B,
			rf_rdata_b);
		exe_opnd_a = pick_exe(fwd.hzd_mem_to_exe_A, fwd.fw_wb_to_exe_A, exe_base_a);
		exe_opnd_b = pick_exe(fwd.hzd_mem_to_exe_B, fwd.fw_wb_to_exe_B, exe_base_b);

		// Load in EXE has no ALU result yet, the JALR base must not take that path
		if (fwd.hzd_exe_to_id_A)
			a_no_exe_fwd_on_stall: assert (!fwd.fw_exe_to_id_A);
	end

endmodule

//--- rtl/pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;

	import rv_isa_pkg::*;

	// Control of one instruction as it moves EXE -> MEM -> WB
	typedef struct packed {
		reg_idx_t rs_a;
		reg_idx_t rs_b;
		reg_idx_t rd;
		logic     wr_en;
		wb_src_t  sel_data;
		opcode_t  opcode;
		logic     is_comp;
		logic     comp_use_a;
		logic     comp_use_b;
	} stage_ctrl_t;

	// ID view, stage fields plus operand steering
	typedef struct packed {
		stage_ctrl_t stage;
		logic        sel_op_a;
		logic        sel_op_b;
		logic        is_stype;
		imm_sel_t    imm_select;
		logic        sel_op_br;
	} id_ctrl_t;

	// Forward and load-use flags, all valid in the same cycle
	typedef struct packed {
		logic fw_exe_to_id_A;
		logic fw_exe_to_id_B;
		logic fw_mem_to_id_A;
		logic fw_mem_to_id_B;
		logic fw_wb_to_id_A;
		logic fw_wb_to_id_B;
		logic fw_wb_to_exe_A;
		logic fw_wb_to_exe_B;
		logic hzd_exe_to_id_A;
		logic hzd_mem_to_exe_A;
		logic hzd_mem_to_exe_B;
	} fwd_flags_t;

	// Empty slot, no write and rd x0
	localparam stage_ctrl_t ctrl_bubble = '0;

endpackage

//--- rtl/rv_isa_pkg.sv
package rv_isa_pkg;

	// Register index, x0..x31
	typedef logic [4:0] reg_idx_t;

	// Major opcode field, instr[6:0]
	typedef logic [6:0] opcode_t;

	// Data path word
	typedef logic [31:0] xlen_word_t;

	// Full instruction word, compressed ones arrive expanded
	typedef logic [31:0] instr_t;

	// Immediate format select
	typedef logic [2:0] imm_sel_t;

	// Write-back source select
	typedef logic [2:0] wb_src_t;

	// Hardwired zero register
	localparam reg_idx_t reg_x0 = 5'd0;

	// RV32I major opcodes
	localparam opcode_t op_lui    = 7'h37;
	localparam opcode_t op_auipc  = 7'h17;
	localparam opcode_t op_jal    = 7'h6f;
	localparam opcode_t op_jalr   = 7'h67;
	localparam opcode_t op_branch = 7'h63;
	localparam opcode_t op_load   = 7'h03;
	localparam opcode_t op_store  = 7'h23;
	localparam opcode_t op_op_imm = 7'h13;
	localparam opcode_t op_op     = 7'h33;

	// Immediate formats
	localparam imm_sel_t imm_i = 3'd0;
	localparam imm_sel_t imm_s = 3'd1;
	localparam imm_sel_t imm_u = 3'd2;
	localparam imm_sel_t imm_b = 3'd3;
	localparam imm_sel_t imm_j = 3'd4;

	// Write-back sources, load data is the late one
	localparam wb_src_t wb_alu  = 3'd0;
	localparam wb_src_t wb_pc4  = 3'd1;
	localparam wb_src_t wb_imm  = 3'd2;
	localparam wb_src_t wb_load = 3'd3;

endpackage

//--- rtl/stage_tracker.sv
`timescale 1ns/1ns

module stage_tracker
	import rv_isa_pkg::*;
	import pipe_ctrl_pkg::*;
(
	input  logic        clk,
	input  logic        rst,
	input  id_ctrl_t    id_ctrl,
	input  logic        stall,
	input  xlen_word_t  id_opnd_a,
	input  xlen_word_t  id_opnd_b,
	output stage_ctrl_t exe_ctrl,
	output stage_ctrl_t mem_ctrl,
	output stage_ctrl_t wb_ctrl,
	output xlen_word_t  exe_base_a,
	output xlen_word_t  exe_base_b
);

	stage_ctrl_t exe_q;
	stage_ctrl_t mem_q;
	stage_ctrl_t wb_q;
	xlen_word_t  base_a_q;
	xlen_word_t  base_b_q;

	// Control pipe, one register per stage
	always_ff @(posedge clk) begin
		if (rst) begin
			exe_q <= ctrl_bubble;
			mem_q <= ctrl_bubble;
			wb_q  <= ctrl_bubble;
		end else begin
			// ID is held by the environment, so EXE gets an empty slot
			if (stall) begin
				exe_q <= ctrl_bubble;
			end else begin
				exe_q <= id_ctrl.stage;
			end
			// Later stages never stop
			mem_q <= exe_q;
			wb_q  <= mem_q;
		end
	end

	// Operand values picked in ID
	always_ff @(posedge clk) begin
		base_a_q <= id_opnd_a;
		base_b_q <= id_opnd_b;
	end

	assign exe_ctrl   = exe_q;
	assign mem_ctrl   = mem_q;
	assign wb_ctrl    = wb_q;
	assign exe_base_a = base_a_q;
	assign exe_base_b = base_b_q;

	// Load stall lasts one cycle, the bubble cannot trigger another
	a_stall_single: assert property (
		@(posedge clk) disable iff (rst)
		stall |=> !stall
	);

	// Bubble carries no write through all three stages
	a_bubble_no_write: assert property (
		@(posedge clk) disable iff (rst)
		stall |=> (!exe_ctrl.wr_en && exe_ctrl.rd == reg_x0)
			##1 !mem_ctrl.wr_en
			##1 !wb_ctrl.wr_en
	);

endmodule

//--- run_sim.sh
#!/bin/sh
# Build with Verilator and run, success only when the pass line appears
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 -f build.f --top-module hazard_ctrl_tb &&
./obj_dir/Vhazard_ctrl_tb | tee /dev/stderr | grep -x "Verification passed" > /dev/null &&
echo "Simulation PASSED" ||
{ echo "Simulation FAILED"; exit 1; }
